// ==== hdl/scroll_config.svh ====
`ifndef SCROLL_CONFIG_SVH
`define SCROLL_CONFIG_SVH

// bar and scroll geometry, in pixels
`define BAR_WIDTH       128
`define BAR_HEIGHT      12
`define BARS_PER_SCROLL 4
`define NUM_SCROLLS     6

// scroll area starts one bar width in from the screen edge
`define FIELD_LEFT      128
`define WRAP_SPAN       512
`define SCROLL_STEP     4

// goal square, always on the top row
`define GOAL_SIZE       12
`define GOAL_ROW_Y      12

`endif

// ==== hdl/fieldPkg.sv ====
`default_nettype none

`include "scroll_config.svh"

package fieldPkg;

    // screen position of the player or goal
    typedef logic [11:0] coord_t;

    // horizontal scroll offset, wraps with the 9-bit width
    typedef logic [$clog2(`WRAP_SPAN)-1:0] offset_t;

    typedef logic [$clog2(`BARS_PER_SCROLL)-1:0] barIdx_t;

    // one visible bit per scroll
    typedef logic [`NUM_SCROLLS-1:0] scrollMask_t;

endpackage

`default_nettype wire

// ==== hdl/objectPkg.sv ====
`default_nettype none

package objectPkg;

    // object colors, encoded as in the display palette
    typedef enum logic [3:0] {
        RED     = 4'd2,
        CYAN    = 4'd3,
        YELLOW  = 4'd4,
        MAGENTA = 4'd5,
        WHITE   = 4'd6,
        GREEN   = 4'd7
    } color_e;

    typedef enum logic {
        MOVE_RIGHT = 1'b0,
        MOVE_LEFT  = 1'b1
    } dir_e;

    // fixed color order of the bars in every scroll
    function automatic color_e barColor(input fieldPkg::barIdx_t idx);
        case (idx)
            2'd0:    return RED;
            2'd1:    return CYAN;
            2'd2:    return YELLOW;
            default: return MAGENTA;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== hdl/scrollPlayerIf.sv ====
`default_nettype none

interface scrollPlayerIf;

    fieldPkg::coord_t  playerHPos;
    fieldPkg::coord_t  playerVPos;
    objectPkg::color_e playerColor;
    // one-cycle move strobe
    logic              stepTick;

    modport source (
        output playerHPos, playerVPos, playerColor, stepTick
    );

    modport sink (
        input playerHPos, playerVPos, playerColor, stepTick
    );

endinterface

`default_nettype wire

// ==== hdl/levelConfig.sv ====
`default_nettype none

`include "scroll_config.svh"

module levelConfig (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [2:0]            level_i,
    output fieldPkg::scrollMask_t scrollMask_o,
    output fieldPkg::coord_t      goalHPos_o
);

    localparam int levelZeroCol = 16;

    fieldPkg::scrollMask_t maskNext;
    fieldPkg::scrollMask_t scrollMaskQ;
    fieldPkg::coord_t      goalHPosQ;
    int                    goalCol;

    // ==============================
    // level table
    // ==============================
    // level L shows scrolls 0..L, unknown levels fall back to scroll 0
    always_comb begin
        case (level_i)
            3'd0: begin
                maskNext = 6'b000001;
                goalCol  = levelZeroCol;
            end
            3'd1: begin
                maskNext = 6'b000011;
                goalCol  = 8;
            end
            3'd2: begin
                maskNext = 6'b000111;
                goalCol  = 31;
            end
            3'd3: begin
                maskNext = 6'b001111;
                goalCol  = 2;
            end
            3'd4: begin
                maskNext = 6'b011111;
                goalCol  = 24;
            end
            3'd5: begin
                maskNext = 6'b111111;
                goalCol  = 28;
            end
            default: begin
                maskNext = 6'b000001;
                goalCol  = 31;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            scrollMaskQ <= 6'b000001;
            goalHPosQ   <= fieldPkg::coord_t'(`FIELD_LEFT + `GOAL_SIZE * levelZeroCol);
        end else begin
            scrollMaskQ <= maskNext;
            goalHPosQ   <= fieldPkg::coord_t'(`FIELD_LEFT + `GOAL_SIZE * goalCol);
        end
    end

    assign scrollMask_o = scrollMaskQ;
    assign goalHPos_o   = goalHPosQ;

endmodule

`default_nettype wire

// ==== hdl/scrollBank.sv ====
`default_nettype none

`include "scroll_config.svh"

module scrollBank #(
    parameter int                ROW_INDEX = 5,
    parameter objectPkg::dir_e   MOVE_DIR  = objectPkg::MOVE_RIGHT
) (
    input  logic              clk,
    input  logic              rst,
    scrollPlayerIf.sink       player,
    input  logic              visible_i,
    output fieldPkg::offset_t offset_o,
    output logic              onForeignBar_o
);

    // vertical band of this scroll row
    localparam fieldPkg::coord_t bandTop    = fieldPkg::coord_t'(`BAR_HEIGHT * ROW_INDEX);
    localparam fieldPkg::coord_t bandBottom = fieldPkg::coord_t'(`BAR_HEIGHT * (ROW_INDEX + 1));

    localparam fieldPkg::coord_t  fieldLeft  = fieldPkg::coord_t'(`FIELD_LEFT);
    localparam fieldPkg::coord_t  fieldRight = fieldPkg::coord_t'(`FIELD_LEFT + `WRAP_SPAN);
    localparam fieldPkg::offset_t stepSize   = fieldPkg::offset_t'(`SCROLL_STEP);

    fieldPkg::offset_t offsetQ;
    fieldPkg::offset_t relPos;
    fieldPkg::barIdx_t barUnder;
    logic              hInRange;
    logic              vInBand;

    // ==============================
    // motion
    // ==============================
    // keeps moving while hidden, wraps through the 9-bit width
    always_ff @(posedge clk) begin
        if (rst) begin
            offsetQ <= '0;
        end else if (player.stepTick) begin
            if (MOVE_DIR == objectPkg::MOVE_RIGHT) begin
                offsetQ <= offsetQ + stepSize;
            end else begin
                offsetQ <= offsetQ - stepSize;
            end
        end
    end

    assign offset_o = offsetQ;

    // ==============================
    // player on bar test
    // ==============================
    assign hInRange = (player.playerHPos >= fieldLeft) && (player.playerHPos < fieldRight);
    assign vInBand  = (player.playerVPos >= bandTop) && (player.playerVPos < bandBottom);

    // position inside the wrapped row, relative to the shifted bars
    assign relPos   = fieldPkg::offset_t'(player.playerHPos - fieldLeft) - offsetQ;
    assign barUnder = fieldPkg::barIdx_t'(relPos / `BAR_WIDTH);

    // matching color lets the player pass
    assign onForeignBar_o = visible_i && vInBand && hInRange
                         && (objectPkg::barColor(barUnder) != player.playerColor);

endmodule

`default_nettype wire

// ==== hdl/goalMonitor.sv ====
`default_nettype none

`include "scroll_config.svh"

module goalMonitor (
    input  logic                   clk,
    input  logic                   rst,
    scrollPlayerIf.sink            player,
    input  logic [`NUM_SCROLLS-1:0] foreignHits_i,
    input  fieldPkg::coord_t       goalHPos_i,
    output logic                   blocked_o,
    output logic                   levelComplete_o
);

    localparam fieldPkg::coord_t goalTop  = fieldPkg::coord_t'(`GOAL_ROW_Y);
    localparam fieldPkg::coord_t goalSize = fieldPkg::coord_t'(`GOAL_SIZE);

    logic onGoal;
    logic blockedQ;
    logic levelCompleteQ;

    // player inside the goal square
    assign onGoal = (player.playerHPos >= goalHPos_i)
                 && (player.playerHPos < goalHPos_i + goalSize)
                 && (player.playerVPos >= goalTop)
                 && (player.playerVPos < goalTop + goalSize);

    // ==============================
    // registered status
    // ==============================
    always_ff @(posedge clk) begin
        if (rst) begin
            blockedQ       <= 1'b0;
            levelCompleteQ <= 1'b0;
        end else begin
            // any scroll hit blocks the move
            blockedQ       <= |foreignHits_i;
            levelCompleteQ <= onGoal;
        end
    end

    assign blocked_o       = blockedQ;
    assign levelComplete_o = levelCompleteQ;

endmodule

`default_nettype wire

// ==== hdl/scrollField.sv ====
`default_nettype none

`include "scroll_config.svh"

module scrollField (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic [2:0]                              level_i,
    input  fieldPkg::coord_t                        playerHPos_i,
    input  fieldPkg::coord_t                        playerVPos_i,
    input  logic [3:0]                              playerColor_i,
    input  logic                                    stepTick_i,
    output fieldPkg::scrollMask_t                   scrollVisible_o,
    output fieldPkg::offset_t [`NUM_SCROLLS-1:0]    hOffset_o,
    output fieldPkg::coord_t                        goalHPos_o,
    output fieldPkg::coord_t                        goalVPos_o,
    output logic                                    blocked_o,
    output logic                                    levelComplete_o
);

    // screen row of each scroll, in bar heights
    localparam int scrollRow [`NUM_SCROLLS] = '{5, 10, 17, 22, 29, 34};

    logic [`NUM_SCROLLS-1:0] foreignHits;

    // ==============================
    // player bus
    // ==============================
    scrollPlayerIf playerBus ();

    assign playerBus.playerHPos  = playerHPos_i;
    assign playerBus.playerVPos  = playerVPos_i;
    assign playerBus.playerColor = objectPkg::color_e'(playerColor_i);
    assign playerBus.stepTick    = stepTick_i;

    // goal row never moves
    assign goalVPos_o = fieldPkg::coord_t'(`GOAL_ROW_Y);

    levelConfig uLevelConfig (
        .clk          (clk),
        .rst          (rst),
        .level_i      (level_i),
        .scrollMask_o (scrollVisible_o),
        .goalHPos_o   (goalHPos_o)
    );

    // ==============================
    // scrolls
    // ==============================
    // even scrolls move right, odd ones left
    for (genvar s = 0; s < `NUM_SCROLLS; s++) begin : gScroll
        scrollBank #(
            .ROW_INDEX (scrollRow[s]),
            .MOVE_DIR  ((s % 2 == 0) ? objectPkg::MOVE_RIGHT : objectPkg::MOVE_LEFT)
        ) uScrollBank (
            .clk            (clk),
            .rst            (rst),
            .player         (playerBus.sink),
            .visible_i      (scrollVisible_o[s]),
            .offset_o       (hOffset_o[s]),
            .onForeignBar_o (foreignHits[s])
        );
    end

    goalMonitor uGoalMonitor (
        .clk             (clk),
        .rst             (rst),
        .player          (playerBus.sink),
        .foreignHits_i   (foreignHits),
        .goalHPos_i      (goalHPos_o),
        .blocked_o       (blocked_o),
        .levelComplete_o (levelComplete_o)
    );

endmodule

`default_nettype wire

// ==== verification/clockGen.sv ====
`default_nettype none

module clockGen #(
    parameter int RESET_CYCLES = 10
) (
    output logic clk_o,
    output logic rst_o
);
    timeunit 1ns;
    timeprecision 1ps;

    // 4 ns period
    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    // released just after a rising edge, like the other inputs
    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1 rst_o = 1'b0;
    end

endmodule

`default_nettype wire

// ==== verification/scrollFieldTb.sv ====
`default_nettype none

`include "scroll_config.svh"

module scrollFieldTb;
    timeunit 1ns;
    timeprecision 1ps;

    // test lengths in cycles, the run stops at half again their sum
    localparam int resetLen   = 20;
    localparam int levelLen   = 8 * 2;
    localparam int motionLen  = 200;
    localparam int blockLen   = 1500 + 2;
    localparam int hiddenLen  = 64 + 2;
    localparam int goalLen    = 8 * 5;
    localparam int cycleLimit =
        (resetLen + levelLen + motionLen + blockLen + hiddenLen + goalLen) * 3 / 2;

    // screen rows of the scrolls, bar colors left to right, goal columns per level
    localparam int rowOf [`NUM_SCROLLS] = '{5, 10, 17, 22, 29, 34};
    localparam int barColorTbl [4] = '{2, 3, 4, 5};
    localparam int goalCols [6] = '{16, 8, 31, 2, 24, 28};

    logic                                 clk;
    logic                                 rst;
    logic [2:0]                           level;
    fieldPkg::coord_t                     playerHPos;
    fieldPkg::coord_t                     playerVPos;
    logic [3:0]                           playerColor;
    logic                                 stepTick;
    fieldPkg::scrollMask_t                scrollVisible;
    fieldPkg::offset_t [`NUM_SCROLLS-1:0] hOffset;
    fieldPkg::coord_t                     goalHPos;
    fieldPkg::coord_t                     goalVPos;
    logic                                 blocked;
    logic                                 levelComplete;

    // reference model state
    int         expOffset [`NUM_SCROLLS];
    logic [5:0] expMask;
    int         expGoalH;
    logic       expBlocked;
    logic       expComplete;

    int   errCount    = 0;
    int   testsRun    = 0;
    int   testsFailed = 0;
    int   cycleCount  = 0;
    logic checkEn     = 1'b0;

    clockGen uClockGen (
        .clk_o (clk),
        .rst_o (rst)
    );

    scrollField UUT (
        .clk             (clk),
        .rst             (rst),
        .level_i         (level),
        .playerHPos_i    (playerHPos),
        .playerVPos_i    (playerVPos),
        .playerColor_i   (playerColor),
        .stepTick_i      (stepTick),
        .scrollVisible_o (scrollVisible),
        .hOffset_o       (hOffset),
        .goalHPos_o      (goalHPos),
        .goalVPos_o      (goalVPos),
        .blocked_o       (blocked),
        .levelComplete_o (levelComplete)
    );

    // ==============================
    // reference model
    // ==============================
    function automatic logic [5:0] levelMask(int lvl);
        if (lvl >= 0 && lvl <= 5) begin
            return 6'((1 << (lvl + 1)) - 1);
        end
        return 6'b000001;
    endfunction

    function automatic int goalColumn(int lvl);
        if (lvl >= 0 && lvl <= 5) begin
            return goalCols[lvl];
        end
        return 31;
    endfunction

    // visible, in band, in range, and on a bar of another color
    function automatic logic hitRule(int s, int h, int v, int c);
        int top;
        int p;
        top = `BAR_HEIGHT * rowOf[s];
        if (!expMask[s] || v < top || v >= top + `BAR_HEIGHT) begin
            return 1'b0;
        end
        if (h < `FIELD_LEFT || h >= `FIELD_LEFT + `WRAP_SPAN) begin
            return 1'b0;
        end
        p = ((h - `FIELD_LEFT - expOffset[s]) % `WRAP_SPAN + `WRAP_SPAN) % `WRAP_SPAN;
        return barColorTbl[p / `BAR_WIDTH] != c;
    endfunction

    always @(posedge clk) begin : modelUpdate
        logic anyHit;
        logic onGoal;
        int   h;
        int   v;
        h = int'(playerHPos);
        v = int'(playerVPos);
        anyHit = 1'b0;
        for (int s = 0; s < `NUM_SCROLLS; s++) begin
            if (hitRule(s, h, v, int'(playerColor))) begin
                anyHit = 1'b1;
            end
        end
        onGoal = (h >= expGoalH) && (h < expGoalH + `GOAL_SIZE)
              && (v >= `GOAL_ROW_Y) && (v < `GOAL_ROW_Y + `GOAL_SIZE);
        if (rst) begin
            for (int s = 0; s < `NUM_SCROLLS; s++) begin
                expOffset[s] = 0;
            end
            expMask     = 6'b000001;
            expGoalH    = `FIELD_LEFT + `GOAL_SIZE * goalColumn(0);
            expBlocked  = 1'b0;
            expComplete = 1'b0;
        end else begin
            expBlocked  = anyHit;
            expComplete = onGoal;
            // even scrolls move right, odd ones left
            for (int s = 0; s < `NUM_SCROLLS; s++) begin
                if (stepTick && s % 2 == 0) begin
                    expOffset[s] = (expOffset[s] + `SCROLL_STEP) % `WRAP_SPAN;
                end else if (stepTick) begin
                    expOffset[s] = (expOffset[s] + `WRAP_SPAN - `SCROLL_STEP) % `WRAP_SPAN;
                end
            end
            expMask  = levelMask(int'(level));
            expGoalH = `FIELD_LEFT + `GOAL_SIZE * goalColumn(int'(level));
        end
    end

    // ==============================
    // checks
    // ==============================
    task automatic checkValue(string name, logic [31:0] expected, logic [31:0] actual);
        assert (actual === expected) else begin
            errCount++;
            $display("FAIL %s expected %0h got %0h", name, expected, actual);
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (checkEn) begin
            checkValue("scrollVisible_o", 32'(expMask), 32'(scrollVisible));
            for (int s = 0; s < `NUM_SCROLLS; s++) begin
                checkValue($sformatf("hOffset_o[%0d]", s), expOffset[s], 32'(hOffset[s]));
            end
            checkValue("goalHPos_o", expGoalH, 32'(goalHPos));
            checkValue("goalVPos_o", `GOAL_ROW_Y, 32'(goalVPos));
            checkValue("blocked_o", 32'(expBlocked), 32'(blocked));
            checkValue("levelComplete_o", 32'(expComplete), 32'(levelComplete));
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("timeout: the tests did not finish within %0d cycles", cycleLimit);
            $display("Errors found");
            $finish;
        end
    end

    // ==============================
    // stimulus
    // ==============================
    task automatic nextCycle();
        @(posedge clk);
        #1;
    endtask

    // top-left corner is outside every band and every goal
    task automatic parkPlayer();
        playerHPos = '0;
        playerVPos = '0;
        stepTick   = 1'b0;
    endtask

    task automatic reportTest(string name, int errsBefore);
        testsRun++;
        if (errCount == errsBefore) begin
            $display("test %s: pass", name);
        end else begin
            testsFailed++;
            $display("test %s: fail, %0d errors", name, errCount - errsBefore);
        end
    endtask

    task automatic checkResetState();
        int errsBefore;
        errsBefore = errCount;
        wait (rst == 1'b0);
        nextCycle();
        checkValue("scrollVisible_o", 32'h1, 32'(scrollVisible));
        checkValue("goalHPos_o", `FIELD_LEFT + `GOAL_SIZE * 16, 32'(goalHPos));
        checkValue("blocked_o", 0, 32'(blocked));
        checkValue("levelComplete_o", 0, 32'(levelComplete));
        for (int s = 0; s < `NUM_SCROLLS; s++) begin
            checkValue($sformatf("hOffset_o[%0d]", s), 0, 32'(hOffset[s]));
        end
        reportTest("reset state", errsBefore);
    endtask

    task automatic decodeLevels();
        int errsBefore;
        errsBefore = errCount;
        for (int lvl = 0; lvl < 8; lvl++) begin
            level = 3'(lvl);
            nextCycle();
            checkValue("scrollVisible_o", 32'(levelMask(lvl)), 32'(scrollVisible));
            checkValue("goalHPos_o", `FIELD_LEFT + `GOAL_SIZE * goalColumn(lvl),
                       32'(goalHPos));
            nextCycle();
        end
        reportTest("level decode", errsBefore);
    endtask

    task automatic moveScrolls();
        int errsBefore;
        errsBefore = errCount;
        parkPlayer();
        for (int i = 0; i < motionLen; i++) begin
            stepTick = 1'($urandom_range(1, 0));
            nextCycle();
        end
        stepTick = 1'b0;
        reportTest("scroll motion", errsBefore);
    endtask

    task automatic blockByColor();
        int errsBefore;
        int s;
        int blockedSeen;
        int passedSeen;
        errsBefore  = errCount;
        blockedSeen = 0;
        passedSeen  = 0;
        level = 3'd5;
        parkPlayer();
        nextCycle();
        nextCycle();
        for (int i = 0; i < blockLen - 2; i++) begin
            s = $urandom_range(5, 0);
            playerVPos  = 12'(`BAR_HEIGHT * rowOf[s] + $urandom_range(11, 0));
            playerHPos  = 12'(`FIELD_LEFT + $urandom_range(511, 0));
            playerColor = 4'($urandom_range(7, 2));
            stepTick    = 1'($urandom_range(1, 0));
            nextCycle();
            if (expBlocked) begin
                blockedSeen++;
            end else begin
                passedSeen++;
            end
        end
        parkPlayer();
        assert (blockedSeen > 0 && passedSeen > 0) else begin
            errCount++;
            $display("color blocking never saw both a blocked and a matching-color case");
        end
        reportTest("color blocking", errsBefore);
    endtask

    task automatic hideScrolls();
        int errsBefore;
        errsBefore = errCount;
        level = 3'd0;
        parkPlayer();
        nextCycle();
        nextCycle();
        for (int i = 0; i < hiddenLen - 2; i++) begin
            playerVPos  = 12'(`BAR_HEIGHT * rowOf[3] + $urandom_range(11, 0));
            playerHPos  = 12'(`FIELD_LEFT + $urandom_range(511, 0));
            // white is foreign to every bar
            playerColor = 4'd6;
            nextCycle();
            checkValue("blocked_o", 0, 32'(blocked));
        end
        parkPlayer();
        reportTest("hidden scrolls", errsBefore);
    endtask

    task automatic reachGoal();
        int errsBefore;
        int gx;
        errsBefore = errCount;
        for (int lvl = 0; lvl < 8; lvl++) begin
            level = 3'(lvl);
            parkPlayer();
            nextCycle();
            nextCycle();
            gx = `FIELD_LEFT + `GOAL_SIZE * goalColumn(lvl);
            playerHPos = 12'(gx + $urandom_range(11, 0));
            playerVPos = 12'(`GOAL_ROW_Y + $urandom_range(11, 0));
            nextCycle();
            checkValue("levelComplete_o", 1, 32'(levelComplete));
            // one pixel past the right edge
            playerHPos = 12'(gx + `GOAL_SIZE);
            nextCycle();
            checkValue("levelComplete_o", 0, 32'(levelComplete));
            // one pixel above the top edge
            playerHPos = 12'(gx);
            playerVPos = 12'(`GOAL_ROW_Y - 1);
            nextCycle();
            checkValue("levelComplete_o", 0, 32'(levelComplete));
        end
        reportTest("goal", errsBefore);
    endtask

    initial begin : mainSeq
        void'($urandom(32'h81fdb4fe));
        level       = 3'd0;
        playerHPos  = '0;
        playerVPos  = '0;
        playerColor = 4'd2;
        stepTick    = 1'b0;
        @(posedge clk);
        #1 checkEn = 1'b1;
        checkResetState();
        decodeLevels();
        moveScrolls();
        blockByColor();
        hideScrolls();
        reachGoal();
        $display("tests run %0d, tests failed %0d, errors %0d",
                 testsRun, testsFailed, errCount);
        if (errCount == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+hdl
hdl/fieldPkg.sv
hdl/objectPkg.sv
hdl/scrollPlayerIf.sv
hdl/levelConfig.sv
hdl/scrollBank.sv
hdl/goalMonitor.sv
hdl/scrollField.sv
verification/clockGen.sv
verification/scrollFieldTb.sv

// ==== Makefile ====
# Verilator build and run for the scroll field testbench

TOP := scrollFieldTb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f sim.f

sim:
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module $(TOP) \
		-Mdir obj_dir -f sim.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^No errors$$"

clean:
	rm -rf obj_dir
